//--- rtl/sd_cmd_pkg.sv
/* Shared types and constants for the SD command path. Only 48-bit responses are handled,
   so R2 frames and busy signalling are outside this design. */

package sd_cmd_pkg;

	// Host side FSM
	typedef enum logic [1:0] {
		ST_WAITING_CMD,
		ST_SETUP,
		ST_WAITING_RESPONSE,
		ST_FINISHING
	} master_state_t;

	// Link side FSM
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SEND,
		PH_WAIT_START,
		PH_RECEIVE,
		PH_REPORT
	} phys_state_t;

	// Index over argument
	localparam int CMD_WORD_W = 38;
	localparam int FRAME_W = 48;
	localparam int CRC_W = 7;

	// Host cycles per SD bit, sd_clk high in the second half
	localparam int CLK_DIV = 4;
	localparam int DIV_W = $clog2(CLK_DIV);

	// Bit periods allowed between the end bit and a response start bit
	localparam int RESP_TIMEOUT_BITS = 64;

	// Must hold both FRAME_W and RESP_TIMEOUT_BITS
	localparam int CNT_W = 7;

endpackage

//--- rtl/cmd_link_if.sv
/* Level REQ/ACK link between the host FSM and the physical layer, one clock domain only. */
`timescale 1ns/1ps

interface cmd_link_if;
	import sd_cmd_pkg::*;

	logic req;
	logic [CMD_WORD_W-1:0] cmd_word;
	logic ack_to_master;
	logic req_to_master;
	logic ack_to_phys;
	logic [FRAME_W-1:0] response;
	logic timeout;
	logic crc_error;
	logic inactive;

	modport master (
		output req, cmd_word, ack_to_phys,
		input ack_to_master, req_to_master, response, timeout, crc_error, inactive
	);

	modport phys (
		input req, cmd_word, ack_to_phys,
		output ack_to_master, req_to_master, response, timeout, crc_error, inactive
	);

endinterface

//--- rtl/cmd_shifter.sv
/* Frame register, MSB first both ways. crc_insert is only honoured together with shift. */
`timescale 1ns/1ps

module cmd_shifter (
	input logic CLK_host,
	input logic rst,
	input logic load,
	input logic shift,
	input logic [sd_cmd_pkg::FRAME_W-1:0] frame_in,
	input logic [sd_cmd_pkg::CRC_W-1:0] crc_in,
	input logic crc_insert,
	input logic serial_in,
	output logic serial_out,
	output logic [sd_cmd_pkg::FRAME_W-1:0] frame
);
	import sd_cmd_pkg::*;

	logic [FRAME_W-1:0] frame_q;

	// Idle line level after reset
	always_ff @(posedge CLK_host) begin
		if (rst) begin
			frame_q <= '1;
		end else if (load) begin
			frame_q <= frame_in;
		end else if (shift && crc_insert) begin
			// CRC MSB leaves now, the rest waits above the end bit
			frame_q <= {crc_in[CRC_W-2:0], frame_q[FRAME_W-CRC_W-1:0], serial_in};
		end else if (shift) begin
			frame_q <= {frame_q[FRAME_W-2:0], serial_in};
		end
	end

	assign serial_out = crc_insert ? crc_in[CRC_W-1] : frame_q[FRAME_W-1];
	assign frame = frame_q;

endmodule

//--- rtl/crc7_unit.sv
/* Serial CRC7, x^7 + x^3 + 1, one bit per step. clear wins over step. */
`timescale 1ns/1ps

module crc7_unit (
	input logic CLK_host,
	input logic rst,
	input logic clear,
	input logic step,
	input logic data_bit,
	output logic [sd_cmd_pkg::CRC_W-1:0] crc
);
	import sd_cmd_pkg::*;

	logic fb;
	logic [CRC_W-1:0] crc_q;

	assign fb = data_bit ^ crc_q[CRC_W-1];

	always_ff @(posedge CLK_host) begin
		if (rst || clear) begin
			crc_q <= '0;
		end else if (step) begin
			// Taps at x^3 and x^0
			crc_q <= {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};
		end
	end

	assign crc = crc_q;

endmodule

//--- rtl/response_timer.sv
/* Counts ticks from start. limit may change between spans; expired follows it at once. */
`timescale 1ns/1ps

module response_timer (
	input logic CLK_host,
	input logic rst,
	input logic start,
	input logic tick,
	input logic [sd_cmd_pkg::CNT_W-1:0] limit,
	output logic expired
);
	import sd_cmd_pkg::*;

	logic [CNT_W-1:0] count;

	always_ff @(posedge CLK_host) begin
		if (rst) begin
			count <= '0;
		end else if (start) begin
			count <= '0;
		end else if (tick) begin
			count <= count + 1'b1;
		end
	end

	assign expired = (count == limit);

endmodule

//--- rtl/cmd_physical.sv
/* CMD line engine, bit rate is CLK_host / CLK_DIV with a free-running sd_clk.
   card_inactive aborts any frame and releases the line. */
`timescale 1ns/1ps

module cmd_physical (
	input logic CLK_host,
	input logic rst,
	input logic card_inactive,
	cmd_link_if.phys link,
	input logic cmd_in,
	output logic cmd_out,
	output logic cmd_oe,
	output logic sd_clk
);
	import sd_cmd_pkg::*;

	phys_state_t state;
	logic [DIV_W-1:0] div_cnt;
	logic strobe;
	logic crc_done;
	logic timed_out;
	logic in_send, in_wait, in_recv;
	logic load, shift_en, tx_insert, tx_release, rx_start;
	logic crc_clear, crc_step, crc_bit;
	logic timer_start, timer_tick, expired;
	logic [CNT_W-1:0] limit;
	logic serial_out;
	logic [FRAME_W-1:0] frame;
	logic [CRC_W-1:0] crc;

	// Bit strobe on the last host cycle of each bit
	always_ff @(posedge CLK_host) begin
		if (rst) begin
			div_cnt <= '0;
		end else if (strobe) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign strobe = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign sd_clk = (div_cnt >= DIV_W'(CLK_DIV / 2));

	assign in_send = (state == PH_SEND);
	assign in_wait = (state == PH_WAIT_START);
	assign in_recv = (state == PH_RECEIVE);

	assign load = (state == PH_IDLE) && link.req && !card_inactive;
	// After 40 bits the CRC takes the place of frame bits 7..1
	assign tx_insert = strobe && in_send && !crc_done && expired;
	assign tx_release = strobe && in_send && crc_done && expired;
	assign rx_start = strobe && in_wait && !cmd_in;

	assign shift_en = (strobe && in_send && !tx_release) || rx_start || (strobe && in_recv);
	assign crc_step = (strobe && (in_send || in_recv) && !crc_done && !expired) || rx_start;
	assign crc_bit = in_send ? serial_out : cmd_in;
	assign crc_clear = load || tx_release;

	assign timer_start = load || tx_release || rx_start;
	assign timer_tick = strobe && (in_send || in_wait || in_recv);

	// Two spans per phase, CRC-covered bits first
	always_comb begin
		case (state)
			PH_SEND: limit = crc_done ? CNT_W'(FRAME_W) : CNT_W'(FRAME_W - CRC_W - 1);
			PH_WAIT_START: limit = CNT_W'(RESP_TIMEOUT_BITS);
			PH_RECEIVE: limit = crc_done ? CNT_W'(FRAME_W - 1) : CNT_W'(FRAME_W - CRC_W - 2);
			default: limit = CNT_W'(FRAME_W);
		endcase
	end

	always_ff @(posedge CLK_host) begin
		if (rst || card_inactive) begin
			state <= PH_IDLE;
			cmd_oe <= 1'b0;
			cmd_out <= 1'b1;
			crc_done <= 1'b0;
			timed_out <= 1'b0;
		end else begin
			case (state)
				PH_IDLE: begin
					if (load) begin
						state <= PH_SEND;
						crc_done <= 1'b0;
						timed_out <= 1'b0;
					end
				end
				PH_SEND: begin
					if (tx_release) begin
						state <= PH_WAIT_START;
						cmd_oe <= 1'b0;
						cmd_out <= 1'b1;
						crc_done <= 1'b0;
					end else if (strobe) begin
						cmd_oe <= 1'b1;
						cmd_out <= serial_out;
						if (tx_insert) begin
							crc_done <= 1'b1;
						end
					end
				end
				PH_WAIT_START: begin
					if (rx_start) begin
						state <= PH_RECEIVE;
					end else if (expired) begin
						state <= PH_REPORT;
						timed_out <= 1'b1;
					end
				end
				PH_RECEIVE: begin
					if (expired && crc_done) begin
						state <= PH_REPORT;
					end else if (expired) begin
						crc_done <= 1'b1;
					end
				end
				PH_REPORT: begin
					if (timed_out || link.ack_to_phys) begin
						state <= PH_IDLE;
					end
				end
				default: begin
					state <= PH_IDLE;
				end
			endcase
		end
	end

	cmd_shifter u_shifter (
		.CLK_host (CLK_host),
		.rst (rst),
		.load (load),
		.shift (shift_en),
		.frame_in ({1'b0, 1'b1, link.cmd_word, {CRC_W{1'b0}}, 1'b1}),
		.crc_in (crc),
		.crc_insert (tx_insert),
		.serial_in (cmd_in),
		.serial_out (serial_out),
		.frame (frame)
	);

	crc7_unit u_crc (
		.CLK_host (CLK_host),
		.rst (rst),
		.clear (crc_clear),
		.step (crc_step),
		.data_bit (crc_bit),
		.crc (crc)
	);

	response_timer u_timer (
		.CLK_host (CLK_host),
		.rst (rst),
		.start (timer_start),
		.tick (timer_tick),
		.limit (limit),
		.expired (expired)
	);

	assign link.ack_to_master = load;
	assign link.req_to_master = (state == PH_REPORT) && !timed_out;
	assign link.timeout = (state == PH_REPORT) && timed_out;
	assign link.response = frame;
	assign link.crc_error = (crc != frame[CRC_W:1]);
	assign link.inactive = card_inactive;

endmodule

//--- rtl/cmd_master.sv
/* Host-facing command FSM. new_cmd is ignored while cmd_busy is high, and
   response_status keeps the last good response across timeouts. */
`timescale 1ns/1ps

module cmd_master (
	input logic CLK_host,
	input logic rst,
	input logic new_cmd,
	input logic [5:0] cmd_index,
	input logic [31:0] cmd_arg,
	cmd_link_if.master link,
	output logic cmd_busy,
	output logic cmd_complete,
	output logic timeout_error,
	output logic crc_error,
	output logic [31:0] response_status
);
	import sd_cmd_pkg::*;

	master_state_t state;
	logic timeout_seen;
	logic [CMD_WORD_W-1:0] cmd_word_q;

	always_ff @(posedge CLK_host) begin
		if (rst || link.inactive) begin
			state <= ST_WAITING_CMD;
		end else begin
			case (state)
				ST_WAITING_CMD: begin
					if (new_cmd) begin
						state <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					if (link.ack_to_master) begin
						state <= ST_WAITING_RESPONSE;
					end
				end
				ST_WAITING_RESPONSE: begin
					if (link.req_to_master || link.timeout) begin
						state <= ST_FINISHING;
					end
				end
				ST_FINISHING: begin
					state <= ST_WAITING_CMD;
				end
				default: begin
					state <= ST_WAITING_CMD;
				end
			endcase
		end
	end

	// Command held for the physical layer
	always_ff @(posedge CLK_host) begin
		if (state == ST_WAITING_CMD && new_cmd) begin
			cmd_word_q <= {cmd_index, cmd_arg};
		end
	end

	// Result captured as the link reports, shown from ST_FINISHING on
	always_ff @(posedge CLK_host) begin
		if (rst) begin
			timeout_seen <= 1'b0;
			crc_error <= 1'b0;
			response_status <= '0;
		end else if (state == ST_WAITING_RESPONSE && !link.inactive) begin
			if (link.req_to_master) begin
				response_status <= link.response[39:8];
				crc_error <= link.crc_error;
				timeout_seen <= 1'b0;
			end else if (link.timeout) begin
				crc_error <= 1'b0;
				timeout_seen <= 1'b1;
			end
		end
	end

	assign link.cmd_word = cmd_word_q;
	assign link.req = (state == ST_SETUP) || (state == ST_WAITING_RESPONSE);
	// Answered in the same cycle
	assign link.ack_to_phys = (state == ST_WAITING_RESPONSE) && link.req_to_master;

	assign cmd_busy = (state != ST_WAITING_CMD);
	assign cmd_complete = (state == ST_FINISHING) && !timeout_seen;
	assign timeout_error = (state == ST_FINISHING) && timeout_seen;

endmodule

//--- rtl/sd_cmd_top.sv
/* SD host command path, single CLK_host domain. No data lines, R2 or R1b support. */
`timescale 1ns/1ps

module sd_cmd_top (
	input logic CLK_host,
	input logic rst,
	input logic new_cmd,
	input logic [5:0] cmd_index,
	input logic [31:0] cmd_arg,
	input logic card_inactive,
	input logic cmd_in,
	output logic cmd_busy,
	output logic cmd_complete,
	output logic timeout_error,
	output logic crc_error,
	output logic [31:0] response_status,
	output logic cmd_out,
	output logic cmd_oe,
	output logic sd_clk
);

	cmd_link_if link ();

	cmd_master u_master (
		.CLK_host (CLK_host),
		.rst (rst),
		.new_cmd (new_cmd),
		.cmd_index (cmd_index),
		.cmd_arg (cmd_arg),
		.link (link),
		.cmd_busy (cmd_busy),
		.cmd_complete (cmd_complete),
		.timeout_error (timeout_error),
		.crc_error (crc_error),
		.response_status (response_status)
	);

	cmd_physical u_physical (
		.CLK_host (CLK_host),
		.rst (rst),
		.card_inactive (card_inactive),
		.link (link),
		.cmd_in (cmd_in),
		.cmd_out (cmd_out),
		.cmd_oe (cmd_oe),
		.sd_clk (sd_clk)
	);

endmodule

//--- bench/tb_sd_cmd.sv
/* Random command tests against a behavioral card. The card changes cmd_in on the host
   falling edge after sd_clk falls, so the DUT samples each bit mid-period. */
`timescale 1ns/1ps

module tb_sd_cmd;
	import sd_cmd_pkg::*;

	localparam int SEED = 91;
	localparam int CLK_HALF = 4;
	localparam int NUM_RANDOM = 40;
	localparam int NUM_ABORT = 3;
	localparam int NUM_BUSY = 2;
	localparam int TOTAL_CMDS = NUM_RANDOM + 2 * NUM_ABORT + NUM_BUSY;
	localparam int MAX_CYCLES =
		TOTAL_CMDS * (2 * FRAME_W + RESP_TIMEOUT_BITS + 16) * CLK_DIV + 1000;
	localparam int WAIT_LIMIT = (2 * FRAME_W + RESP_TIMEOUT_BITS) * CLK_DIV;
	localparam int KIND_GOOD = 0;
	localparam int KIND_SILENT = 1;
	localparam int KIND_BAD_CRC = 2;

	logic CLK_host = 1'b0;
	logic rst;
	logic new_cmd;
	logic [5:0] cmd_index;
	logic [31:0] cmd_arg;
	logic card_inactive;
	logic cmd_in;
	logic cmd_busy;
	logic cmd_complete;
	logic timeout_error;
	logic crc_error;
	logic [31:0] response_status;
	logic cmd_out;
	logic cmd_oe;
	logic sd_clk;

	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	int complete_cnt = 0;
	int timeout_cnt = 0;
	int busy_gaps = 0;
	int frames_seen = 0;
	int cap_count = 0;
	bit track_busy = 1'b0;
	logic last_out = 1'b1;
	logic last_sd_clk = 1'b0;
	logic [FRAME_W-1:0] cap_shift = '0;
	logic [FRAME_W-1:0] last_frame = '0;
	logic [31:0] exp_status = '0;

	sd_cmd_top u_dut (
		.CLK_host (CLK_host),
		.rst (rst),
		.new_cmd (new_cmd),
		.cmd_index (cmd_index),
		.cmd_arg (cmd_arg),
		.card_inactive (card_inactive),
		.cmd_in (cmd_in),
		.cmd_busy (cmd_busy),
		.cmd_complete (cmd_complete),
		.timeout_error (timeout_error),
		.crc_error (crc_error),
		.response_status (response_status),
		.cmd_out (cmd_out),
		.cmd_oe (cmd_oe),
		.sd_clk (sd_clk)
	);

	always #CLK_HALF CLK_host = ~CLK_host;

	// Values seen here are the ones held during the cycle before the edge
	always @(posedge CLK_host) begin
		cycles <= cycles + 1;
		if (cmd_complete) complete_cnt <= complete_cnt + 1;
		if (timeout_error) timeout_cnt <= timeout_cnt + 1;
		if (track_busy && !cmd_busy) busy_gaps <= busy_gaps + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped: cycle limit %0d reached before the tests finished",
				MAX_CYCLES);
			$display("tests run: %0d, tests failed: %0d, errors: %0d",
				tests_run, tests_failed, errors);
			$display("** FAIL **");
			$finish;
		end
	end

	// Card receiver, one frame per 48 bits with cmd_oe high
	always @(posedge sd_clk) begin
		if (cmd_oe) begin
			cap_shift = {cap_shift[FRAME_W-2:0], cmd_out};
			cap_count = cap_count + 1;
			if (cap_count == FRAME_W) begin
				last_frame = cap_shift;
				frames_seen = frames_seen + 1;
				cap_count = 0;
			end
		end else begin
			cap_count = 0;
		end
	end

	// A driven CMD bit may only change where sd_clk falls
	always @(negedge CLK_host) begin
		if (cmd_oe && cmd_out !== last_out) begin
			check_equal({last_sd_clk, sd_clk}, 2'b10, "sd_clk phase at a CMD bit change");
		end
		last_out = cmd_out;
		last_sd_clk = sd_clk;
	end

	function automatic logic [6:0] crc7_of(input logic [39:0] bits);
		logic [6:0] c;
		logic fb;
		int i;
		c = '0;
		for (i = 39; i >= 0; i--) begin
			fb = bits[i] ^ c[6];
			c = {c[5:0], 1'b0};
			if (fb) c = c ^ 7'h09;
		end
		return c;
	endfunction

	function automatic logic [47:0] build_frame(input logic dir, input logic [5:0] idx,
			input logic [31:0] payload);
		logic [39:0] body;
		body = {1'b0, dir, idx, payload};
		return {body, crc7_of(body), 1'b1};
	endfunction

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("Test %0d went wrong: %s", tests_run + 1, msg);
		errors++;
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0) tests_failed++;
		$display("test %0d %s: %s", tests_run, name, (test_errors == 0) ? "ok" : "failed");
		test_errors = 0;
	endtask

	task automatic issue_cmd(input logic [5:0] idx, input logic [31:0] arg);
		@(negedge CLK_host);
		new_cmd = 1'b1;
		cmd_index = idx;
		cmd_arg = arg;
		@(negedge CLK_host);
		new_cmd = 1'b0;
		check_equal(cmd_busy, 1'b1, "cmd_busy after new_cmd");
		track_busy = 1'b1;
	endtask

	task automatic drive_response(input logic [FRAME_W-1:0] resp, input int delay);
		int i;
		repeat (delay) @(negedge sd_clk);
		for (i = FRAME_W - 1; i >= 0; i--) begin
			@(negedge sd_clk);
			@(negedge CLK_host);
			cmd_in = resp[i];
		end
	endtask

	task automatic run_command(input int kind, input bit extra_new_cmd, input string name);
		logic [5:0] idx;
		logic [31:0] arg;
		logic [31:0] status;
		logic [FRAME_W-1:0] resp;
		int c0, t0, f0, g0, n, delay, flip;
		idx = $urandom % 64;
		arg = $urandom;
		status = $urandom;
		delay = 2 + $urandom % 7;
		flip = $urandom % 7;
		c0 = complete_cnt;
		t0 = timeout_cnt;
		f0 = frames_seen;
		g0 = busy_gaps;
		issue_cmd(idx, arg);
		if (extra_new_cmd) begin
			repeat (3) @(negedge CLK_host);
			new_cmd = 1'b1;
			cmd_index = ~idx;
			cmd_arg = ~arg;
			@(negedge CLK_host);
			new_cmd = 1'b0;
		end
		n = 0;
		while (frames_seen == f0 && n < WAIT_LIMIT) begin
			@(negedge CLK_host);
			n++;
		end
		if (frames_seen == f0) begin
			report_problem("no command frame appeared on the CMD line");
		end else begin
			check_equal(last_frame, build_frame(1'b1, idx, arg), "command frame");
		end
		if (kind != KIND_SILENT) begin
			resp = build_frame(1'b0, idx, status);
			if (kind == KIND_BAD_CRC) resp[1 + flip] = ~resp[1 + flip];
			drive_response(resp, delay);
		end
		n = 0;
		while (!(cmd_complete || timeout_error) && n < WAIT_LIMIT) begin
			@(negedge CLK_host);
			n++;
		end
		if (!(cmd_complete || timeout_error)) begin
			report_problem("neither cmd_complete nor timeout_error arrived");
		end else if (kind == KIND_SILENT) begin
			check_equal(timeout_error, 1'b1, "timeout_error");
			check_equal(cmd_complete, 1'b0, "cmd_complete on timeout");
			check_equal(response_status, exp_status, "response_status after timeout");
		end else begin
			check_equal(cmd_complete, 1'b1, "cmd_complete");
			check_equal(timeout_error, 1'b0, "timeout_error on response");
			check_equal(crc_error, kind == KIND_BAD_CRC, "crc_error");
			check_equal(response_status, status, "response_status");
			exp_status = status;
		end
		track_busy = 1'b0;
		@(negedge CLK_host);
		check_equal(cmd_busy, 1'b0, "cmd_busy after completion");
		repeat (8) @(negedge CLK_host);
		check_equal(complete_cnt - c0, kind != KIND_SILENT, "cmd_complete pulse count");
		check_equal(timeout_cnt - t0, kind == KIND_SILENT, "timeout_error pulse count");
		check_equal(frames_seen - f0, 1, "frames per command");
		check_equal(busy_gaps - g0, 0, "cycles with cmd_busy low mid-command");
		finish_test(name);
	endtask

	task automatic run_abort();
		int c0, t0, n;
		c0 = complete_cnt;
		t0 = timeout_cnt;
		n = 8 + $urandom % 290;
		issue_cmd($urandom % 64, $urandom);
		repeat (n) @(negedge CLK_host);
		track_busy = 1'b0;
		card_inactive = 1'b1;
		@(negedge CLK_host);
		check_equal(cmd_busy, 1'b0, "cmd_busy one cycle after card_inactive");
		check_equal(cmd_oe, 1'b0, "cmd_oe during abort");
		check_equal(cmd_out, 1'b1, "cmd_out during abort");
		@(negedge CLK_host);
		card_inactive = 1'b0;
		repeat (20) @(negedge CLK_host);
		check_equal(complete_cnt - c0, 0, "cmd_complete pulses after abort");
		check_equal(timeout_cnt - t0, 0, "timeout_error pulses after abort");
		check_equal(response_status, exp_status, "response_status after abort");
		check_equal(cmd_busy, 1'b0, "cmd_busy after abort");
		finish_test("abort");
	endtask

	initial begin
		int i;
		int r;
		int kind;
		rst = 1'b1;
		new_cmd = 1'b0;
		cmd_index = '0;
		cmd_arg = '0;
		card_inactive = 1'b0;
		cmd_in = 1'b1;
		void'($urandom(SEED));
		repeat (2) @(negedge CLK_host);
		check_equal(cmd_busy, 1'b0, "cmd_busy in reset");
		check_equal(cmd_complete, 1'b0, "cmd_complete in reset");
		check_equal(timeout_error, 1'b0, "timeout_error in reset");
		check_equal(crc_error, 1'b0, "crc_error in reset");
		check_equal(cmd_oe, 1'b0, "cmd_oe in reset");
		check_equal(cmd_out, 1'b1, "cmd_out in reset");
		check_equal(sd_clk, 1'b0, "sd_clk in reset");
		finish_test("reset");
		rst = 1'b0;
		// First three commands cover every card behavior
		for (i = 0; i < NUM_RANDOM; i++) begin
			r = $urandom % 4;
			if (i < 3) kind = i;
			else kind = (r == 2) ? KIND_SILENT : ((r == 3) ? KIND_BAD_CRC : KIND_GOOD);
			run_command(kind, 1'b0, (kind == KIND_GOOD) ? "response" :
				((kind == KIND_SILENT) ? "timeout" : "crc error"));
		end
		for (i = 0; i < NUM_ABORT; i++) begin
			run_abort();
			run_command(KIND_GOOD, 1'b0, "command after abort");
		end
		for (i = 0; i < NUM_BUSY; i++) begin
			run_command(KIND_GOOD, 1'b1, "new_cmd while busy");
		end
		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- project.f
rtl/sd_cmd_pkg.sv
rtl/cmd_link_if.sv
rtl/cmd_shifter.sv
rtl/crc7_unit.sv
rtl/response_timer.sv
rtl/cmd_physical.sv
rtl/cmd_master.sv
rtl/sd_cmd_top.sv
bench/tb_sd_cmd.sv

//--- Bender.yml
package:
  name: sd_cmd

sources:
  - rtl/sd_cmd_pkg.sv
  - rtl/cmd_link_if.sv
  - rtl/cmd_shifter.sv
  - rtl/crc7_unit.sv
  - rtl/response_timer.sv
  - rtl/cmd_physical.sv
  - rtl/cmd_master.sv
  - rtl/sd_cmd_top.sv
  - target: simulation
    files:
      - bench/tb_sd_cmd.sv
